/* rtl/rv64_pkg.sv */
// shared widths, encodings and the decoded control struct for the rv64 integer slice
`default_nettype none

package rv64_pkg;

  localparam int XLEN     = 64;
  localparam int NUM_REGS = 32;
  localparam int REG_AW   = 5;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_32     = 7'b0111011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_COPY_B = 4'd10 // lui
  } alu_op_e;

  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } a_sel_e;

  typedef enum logic [1:0] {
    B_RS2  = 2'd0,
    B_IMM  = 2'd1,
    B_FOUR = 2'd2 // link address
  } b_sel_e;

  typedef enum logic [3:0] {
    BR_NONE = 4'd0,
    BR_JAL  = 4'd1,
    BR_JALR = 4'd2,
    BR_BEQ  = 4'd3,
    BR_BNE  = 4'd4,
    BR_BLT  = 4'd5,
    BR_BGE  = 4'd6,
    BR_BLTU = 4'd7,
    BR_BGEU = 4'd8
  } branch_op_e;

  typedef struct packed {
    alu_op_e           alu_op;
    a_sel_e            a_sel;
    b_sel_e            b_sel;
    branch_op_e        branch;
    logic              word_cut; // 32-bit op, sign-extended result
    logic              reg_wen;
    logic              illegal;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm;
  } ctrl_t;

endpackage

`default_nettype wire

/* rtl/rv64_decoder.sv */
// combinational decoder turning a 32-bit instruction into the control struct for execute
`default_nettype none
`timescale 1ns/1ps

module rv64_decoder import rv64_pkg::*; (
  input  wire logic [31:0] i_inst,
  output ctrl_t            o_ctrl
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6; // rv64 shift-immediate form

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign funct6 = i_inst[31:26];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_ctrl          = '0;
    o_ctrl.alu_op   = ALU_ADD;
    o_ctrl.a_sel    = A_RS1;
    o_ctrl.b_sel    = B_RS2;
    o_ctrl.branch   = BR_NONE;
    o_ctrl.rs1      = i_inst[19:15];
    o_ctrl.rs2      = i_inst[24:20];
    o_ctrl.rd       = i_inst[11:7];
    o_ctrl.imm      = imm_i;
    o_ctrl.reg_wen  = 1'b1;
    o_ctrl.illegal  = 1'b0;

    case (opcode)
      OPC_OP: begin
        case (funct3)
          3'b000: begin
            if (funct7 == 7'b0000000) o_ctrl.alu_op = ALU_ADD;
            else if (funct7 == 7'b0100000) o_ctrl.alu_op = ALU_SUB;
            else o_ctrl.illegal = 1'b1; // also catches mul
          end
          3'b001: o_ctrl.alu_op = ALU_SLL;
          3'b010: o_ctrl.alu_op = ALU_SLT;
          3'b011: o_ctrl.alu_op = ALU_SLTU;
          3'b100: o_ctrl.alu_op = ALU_XOR;
          3'b101: begin
            if (funct7 == 7'b0100000) o_ctrl.alu_op = ALU_SRA;
            else o_ctrl.alu_op = ALU_SRL;
          end
          3'b110: o_ctrl.alu_op = ALU_OR;
          default: o_ctrl.alu_op = ALU_AND;
        endcase
        // only sub and sra may carry funct7 = 0100000
        if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 &&
            (funct3 == 3'b000 || funct3 == 3'b101))) begin
          o_ctrl.illegal = 1'b1;
        end
      end

      OPC_OP_IMM: begin
        o_ctrl.b_sel = B_IMM;
        case (funct3)
          3'b000: o_ctrl.alu_op = ALU_ADD;
          3'b010: o_ctrl.alu_op = ALU_SLT;
          3'b011: o_ctrl.alu_op = ALU_SLTU;
          3'b100: o_ctrl.alu_op = ALU_XOR;
          3'b110: o_ctrl.alu_op = ALU_OR;
          3'b111: o_ctrl.alu_op = ALU_AND;
          3'b001: begin
            o_ctrl.alu_op  = ALU_SLL;
            o_ctrl.illegal = (funct6 != 6'b000000);
          end
          default: begin // 3'b101
            if (funct6 == 6'b000000) o_ctrl.alu_op = ALU_SRL;
            else if (funct6 == 6'b010000) o_ctrl.alu_op = ALU_SRA;
            else o_ctrl.illegal = 1'b1;
          end
        endcase
      end

      OPC_OP_32: begin
        o_ctrl.word_cut = 1'b1;
        if (funct3 == 3'b000 && funct7 == 7'b0000000) o_ctrl.alu_op = ALU_ADD;
        else if (funct3 == 3'b000 && funct7 == 7'b0100000) o_ctrl.alu_op = ALU_SUB;
        else if (funct3 == 3'b001 && funct7 == 7'b0000000) o_ctrl.alu_op = ALU_SLL;
        else if (funct3 == 3'b101 && funct7 == 7'b0000000) o_ctrl.alu_op = ALU_SRL;
        else if (funct3 == 3'b101 && funct7 == 7'b0100000) o_ctrl.alu_op = ALU_SRA;
        else o_ctrl.illegal = 1'b1; // mulw and friends land here
      end

      OPC_OP_IMM_32: begin
        o_ctrl.word_cut = 1'b1;
        o_ctrl.b_sel    = B_IMM;
        if (funct3 == 3'b000) o_ctrl.alu_op = ALU_ADD;
        else if (funct3 == 3'b001 && funct7 == 7'b0000000) o_ctrl.alu_op = ALU_SLL;
        else if (funct3 == 3'b101 && funct7 == 7'b0000000) o_ctrl.alu_op = ALU_SRL;
        else if (funct3 == 3'b101 && funct7 == 7'b0100000) o_ctrl.alu_op = ALU_SRA;
        else o_ctrl.illegal = 1'b1;
      end

      OPC_LUI: begin
        o_ctrl.alu_op = ALU_COPY_B;
        o_ctrl.b_sel  = B_IMM;
        o_ctrl.imm    = imm_u;
      end

      OPC_AUIPC: begin
        o_ctrl.a_sel = A_PC;
        o_ctrl.b_sel = B_IMM;
        o_ctrl.imm   = imm_u;
      end

      OPC_JAL: begin
        o_ctrl.a_sel  = A_PC; // link pc + 4
        o_ctrl.b_sel  = B_FOUR;
        o_ctrl.branch = BR_JAL;
        o_ctrl.imm    = imm_j;
      end

      OPC_JALR: begin
        o_ctrl.a_sel   = A_PC;
        o_ctrl.b_sel   = B_FOUR;
        o_ctrl.branch  = BR_JALR;
        o_ctrl.illegal = (funct3 != 3'b000);
      end

      OPC_BRANCH: begin
        o_ctrl.reg_wen = 1'b0;
        o_ctrl.imm     = imm_b;
        case (funct3)
          3'b000:  o_ctrl.branch = BR_BEQ;
          3'b001:  o_ctrl.branch = BR_BNE;
          3'b100:  o_ctrl.branch = BR_BLT;
          3'b101:  o_ctrl.branch = BR_BGE;
          3'b110:  o_ctrl.branch = BR_BLTU;
          3'b111:  o_ctrl.branch = BR_BGEU;
          default: o_ctrl.illegal = 1'b1;
        endcase
      end

      default: o_ctrl.illegal = 1'b1; // loads, stores, system
    endcase

    // illegal retires as a plain pc + 4 with no write
    if (o_ctrl.illegal) begin
      o_ctrl.reg_wen = 1'b0;
      o_ctrl.branch  = BR_NONE;
    end
  end

endmodule

`default_nettype wire

/* rtl/rv64_regfile.sv */
// general-purpose register file, two combinational reads and one synchronous write
`default_nettype none
`timescale 1ns/1ps

module rv64_regfile import rv64_pkg::*; (
  input  wire logic              i_clk,
  input  wire logic              i_reset,
  input  wire logic [REG_AW-1:0] i_raddr_a,
  input  wire logic [REG_AW-1:0] i_raddr_b,
  input  wire logic [REG_AW-1:0] i_waddr,
  input  wire logic              i_wen,
  input  wire logic [XLEN-1:0]   i_wdata,
  output logic      [XLEN-1:0]   o_rdata_a,
  output logic      [XLEN-1:0]   o_rdata_b
);

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin // x0 never written
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 hardwired to zero
  assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
  assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

`default_nettype wire

/* rtl/rv64_alu.sv */
// 64-bit integer ALU with operand select, 32-bit word forms and branch compare
`default_nettype none
`timescale 1ns/1ps

module rv64_alu import rv64_pkg::*; (
  input  wire ctrl_t           i_ctrl,
  input  wire logic [XLEN-1:0] i_pc,
  input  wire logic [XLEN-1:0] i_rs1,
  input  wire logic [XLEN-1:0] i_rs2,
  output logic      [XLEN-1:0] o_result,
  output logic                 o_cond_true
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [5:0]      shamt;
  logic [XLEN-1:0] srl_src;
  logic [XLEN-1:0] sra_src;
  logic [XLEN-1:0] raw;
  logic            eq;
  logic            lt;
  logic            ltu;

  assign op_a = (i_ctrl.a_sel == A_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.b_sel)
      B_RS2:   op_b = i_rs2;
      B_IMM:   op_b = i_ctrl.imm;
      B_FOUR:  op_b = XLEN'(4);
      default: op_b = '0;
    endcase
  end

  // word forms shift by 5 bits and see only the low word
  assign shamt   = i_ctrl.word_cut ? {1'b0, op_b[4:0]} : op_b[5:0];
  assign srl_src = i_ctrl.word_cut ? {32'b0, op_a[31:0]} : op_a;
  assign sra_src = i_ctrl.word_cut ? {{32{op_a[31]}}, op_a[31:0]} : op_a;

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_ADD:    raw = op_a + op_b;
      ALU_SUB:    raw = op_a - op_b;
      ALU_SLL:    raw = op_a << shamt;
      ALU_SLT:    raw = XLEN'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   raw = XLEN'(op_a < op_b);
      ALU_XOR:    raw = op_a ^ op_b;
      ALU_SRL:    raw = srl_src >> shamt;
      ALU_SRA:    raw = $unsigned($signed(sra_src) >>> shamt);
      ALU_OR:     raw = op_a | op_b;
      ALU_AND:    raw = op_a & op_b;
      ALU_COPY_B: raw = op_b;
      default:    raw = '0;
    endcase
  end

  assign o_result = i_ctrl.word_cut ? {{32{raw[31]}}, raw[31:0]} : raw;

  // branch compare always on the register operands
  assign eq  = (i_rs1 == i_rs2);
  assign lt  = ($signed(i_rs1) < $signed(i_rs2));
  assign ltu = (i_rs1 < i_rs2);

  always_comb begin
    case (i_ctrl.branch)
      BR_JAL,
      BR_JALR: o_cond_true = 1'b1; // unconditional
      BR_BEQ:  o_cond_true = eq;
      BR_BNE:  o_cond_true = !eq;
      BR_BLT:  o_cond_true = lt;
      BR_BGE:  o_cond_true = !lt;
      BR_BLTU: o_cond_true = ltu;
      BR_BGEU: o_cond_true = !ltu;
      default: o_cond_true = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv64_int_core.sv */
// single-cycle rv64 integer decode and execute slice, fed by an external fetch stage
`default_nettype none
`timescale 1ns/1ps

module rv64_int_core import rv64_pkg::*; (
  input  wire logic            i_clk,
  input  wire logic            i_reset,
  input  wire logic            i_valid,
  input  wire logic [31:0]     i_inst,
  input  wire logic [XLEN-1:0] i_pc,
  output logic      [XLEN-1:0] o_result,
  output logic      [XLEN-1:0] o_next_pc,
  output logic                 o_rd_wen,
  output logic                 o_illegal
);

  ctrl_t           ctrl;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            cond_true;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_target;
  logic [XLEN-1:0] jalr_target;

  rv64_decoder u_decoder (
    .i_inst (i_inst),
    .o_ctrl (ctrl)
  );

  rv64_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_raddr_a (ctrl.rs1),
    .i_raddr_b (ctrl.rs2),
    .i_waddr   (ctrl.rd),
    .i_wen     (o_rd_wen),
    .i_wdata   (o_result),
    .o_rdata_a (rs1_data),
    .o_rdata_b (rs2_data)
  );

  rv64_alu u_alu (
    .i_ctrl      (ctrl),
    .i_pc        (i_pc),
    .i_rs1       (rs1_data),
    .i_rs2       (rs2_data),
    .o_result    (o_result),
    .o_cond_true (cond_true)
  );

  assign o_rd_wen  = i_valid && ctrl.reg_wen && !ctrl.illegal;
  assign o_illegal = i_valid && ctrl.illegal;

  assign pc_plus4    = i_pc + XLEN'(4);
  assign pc_target   = i_pc + ctrl.imm;
  assign jalr_target = (rs1_data + ctrl.imm) & ~XLEN'(1); // bit 0 dropped

  always_comb begin
    case (ctrl.branch)
      BR_NONE: o_next_pc = pc_plus4;
      BR_JALR: o_next_pc = jalr_target;
      default: o_next_pc = cond_true ? pc_target : pc_plus4; // jal and taken branches
    endcase
  end

endmodule

`default_nettype wire

/* testbench/rv64_int_core_asserts.sv */
// concurrent checks on the slice top level that bind attaches to every rv64_int_core instance
`default_nettype none
`timescale 1ns/1ps

module rv64_int_core_asserts (
  input wire logic        i_clk,
  input wire logic        i_reset,
  input wire logic        i_valid,
  input wire logic [63:0] o_next_pc,
  input wire logic        o_rd_wen,
  input wire logic        o_illegal
);

  int fail_count = 0;

  illegal_no_write: assert property (
    @(posedge i_clk) disable iff (i_reset) o_illegal |-> !o_rd_wen
  ) else begin
    $error("illegal instruction raised the register write enable");
    fail_count++;
  end

  next_pc_aligned: assert property (
    @(posedge i_clk) disable iff (i_reset) !o_next_pc[0]
  ) else begin
    $error("next pc has bit 0 set");
    fail_count++;
  end

  // no retirement without a valid strobe
  idle_no_write: assert property (
    @(posedge i_clk) !i_valid |-> !o_rd_wen
  ) else begin
    $error("register write enable high while i_valid low");
    fail_count++;
  end

endmodule

bind rv64_int_core rv64_int_core_asserts u_asserts (
  .i_clk     (i_clk),
  .i_reset   (i_reset),
  .i_valid   (i_valid),
  .o_next_pc (o_next_pc),
  .o_rd_wen  (o_rd_wen),
  .o_illegal (o_illegal)
);

`default_nettype wire

/* testbench/tb_rv64_int_core.sv */
// testbench for the rv64 integer slice that checks each retired instruction against a shadow model
`default_nettype none
`timescale 1ns/1ps

module tb_rv64_int_core;

  typedef struct packed {
    logic [63:0] result;
    logic [63:0] next_pc;
    logic        wen;
    logic        ill;
  } expect_t;

  localparam int MAX_CYCLES = 2000; // tests take about 400 cycles

  logic        i_clk;
  logic        i_reset;
  logic        i_valid;
  logic [31:0] i_inst;
  logic [63:0] i_pc;
  logic [63:0] o_result;
  logic [63:0] o_next_pc;
  logic        o_rd_wen;
  logic        o_illegal;

  logic [63:0] shadow [32];
  int          errors;
  int          test_errors;
  int          tests_ok;
  int          tests_bad;
  int          cycles;

  logic [2:0]  f3_list [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  // ld, sd, mul, mulw, csrrw and ecall
  logic [31:0] bad_list [6] = '{32'h0000b283, 32'h0050b023, 32'h022082b3,
                                32'h022082bb, 32'h300092f3, 32'h00000073};

  rv64_int_core dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  function automatic logic [63:0] sext32(input logic [31:0] x);
    return {{32{x[31]}}, x};
  endfunction

  // expected outcome of one instruction under the rv64i rules
  function automatic expect_t ref_model(input logic [31:0] inst, input logic [63:0] pc,
                                        input logic [63:0] regs [32]);
    expect_t            e;
    logic [2:0]         f3;
    logic [6:0]         f7;
    logic [63:0]        a;
    logic [63:0]        b;
    logic [63:0]        imm_i;
    logic signed [31:0] sw;
    f3    = inst[14:12];
    f7    = inst[31:25];
    a     = regs[inst[19:15]];
    b     = regs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    sw    = a[31:0];
    e     = '0;
    e.next_pc = pc + 64'd4;
    e.wen     = 1'b1;
    case (inst[6:0])
      7'h33: begin
        if (f7 == 7'h00) begin
          case (f3)
            3'd0: e.result = a + b;
            3'd1: e.result = a << b[5:0];
            3'd2: e.result = {63'b0, $signed(a) < $signed(b)};
            3'd3: e.result = {63'b0, a < b};
            3'd4: e.result = a ^ b;
            3'd5: e.result = a >> b[5:0];
            3'd6: e.result = a | b;
            default: e.result = a & b;
          endcase
        end else if (f7 == 7'h20 && f3 == 3'd0) e.result = a - b;
        else if (f7 == 7'h20 && f3 == 3'd5) e.result = $signed(a) >>> b[5:0];
        else e.ill = 1'b1;
      end
      7'h13: begin
        case (f3)
          3'd0: e.result = a + imm_i;
          3'd2: e.result = {63'b0, $signed(a) < $signed(imm_i)};
          3'd3: e.result = {63'b0, a < imm_i};
          3'd4: e.result = a ^ imm_i;
          3'd6: e.result = a | imm_i;
          3'd7: e.result = a & imm_i;
          3'd1: begin
            if (inst[31:26] == 6'h00) e.result = a << inst[25:20];
            else e.ill = 1'b1;
          end
          default: begin
            if (inst[31:26] == 6'h00) e.result = a >> inst[25:20];
            else if (inst[31:26] == 6'h10) e.result = $signed(a) >>> inst[25:20];
            else e.ill = 1'b1;
          end
        endcase
      end
      7'h3b: begin
        if (f3 == 3'd0 && f7 == 7'h00) e.result = sext32(a[31:0] + b[31:0]);
        else if (f3 == 3'd0 && f7 == 7'h20) e.result = sext32(a[31:0] - b[31:0]);
        else if (f3 == 3'd1 && f7 == 7'h00) e.result = sext32(a[31:0] << b[4:0]);
        else if (f3 == 3'd5 && f7 == 7'h00) e.result = sext32(a[31:0] >> b[4:0]);
        else if (f3 == 3'd5 && f7 == 7'h20) e.result = sext32(sw >>> b[4:0]);
        else e.ill = 1'b1;
      end
      7'h1b: begin
        if (f3 == 3'd0) e.result = sext32(a[31:0] + imm_i[31:0]);
        else if (f3 == 3'd1 && f7 == 7'h00) e.result = sext32(a[31:0] << inst[24:20]);
        else if (f3 == 3'd5 && f7 == 7'h00) e.result = sext32(a[31:0] >> inst[24:20]);
        else if (f3 == 3'd5 && f7 == 7'h20) e.result = sext32(sw >>> inst[24:20]);
        else e.ill = 1'b1;
      end
      7'h37: e.result = {{32{inst[31]}}, inst[31:12], 12'b0};
      7'h17: e.result = pc + {{32{inst[31]}}, inst[31:12], 12'b0};
      7'h6f: begin
        e.result  = pc + 64'd4;
        e.next_pc = pc + {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'h67: begin
        e.result  = pc + 64'd4;
        e.next_pc = (a + imm_i) & ~64'd1;
        e.ill     = (f3 != 3'd0);
      end
      7'h63: begin
        e.wen = 1'b0;
        if (f3 == 3'd2 || f3 == 3'd3) e.ill = 1'b1;
        else if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b) ||
                 (f3 == 3'd4 && $signed(a) < $signed(b)) ||
                 (f3 == 3'd5 && $signed(a) >= $signed(b)) ||
                 (f3 == 3'd6 && a < b) || (f3 == 3'd7 && a >= b)) begin
          e.next_pc = pc + {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      default: e.ill = 1'b1;
    endcase
    if (e.ill) begin
      e.wen     = 1'b0;
      e.next_pc = pc + 64'd4;
    end
    return e;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Fail %s: got %h expected %h", name, got, exp);
    errors++;
  endtask

  // compare just as the edge retires the instruction, then mirror the write
  always @(posedge i_clk) begin
    expect_t e;
    if (i_reset) begin
      for (int i = 0; i < 32; i++) shadow[i] = '0;
    end else if (i_valid) begin
      e = ref_model(i_inst, i_pc, shadow);
      if (o_illegal !== e.ill) report_mismatch("o_illegal", 64'(o_illegal), 64'(e.ill));
      if (o_rd_wen !== e.wen) report_mismatch("o_rd_wen", 64'(o_rd_wen), 64'(e.wen));
      if (o_next_pc !== e.next_pc) report_mismatch("o_next_pc", o_next_pc, e.next_pc);
      if (e.wen && o_result !== e.result) report_mismatch("o_result", o_result, e.result);
      if (e.wen && i_inst[11:7] != 5'd0) shadow[i_inst[11:7]] = e.result;
    end else if (o_rd_wen !== 1'b0) begin
      $display("write enable was high while no instruction was valid");
      errors++;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [63:0] rand_pc();
    return {$urandom, $urandom} & ~64'h3; // word aligned
  endfunction

  task automatic exec(input logic [31:0] inst);
    @(negedge i_clk);
    i_valid = 1'b1;
    i_inst  = inst;
    i_pc    = rand_pc();
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge i_clk);
      i_valid = 1'b0;
      i_inst  = $urandom;
    end
  endtask

  task automatic finish_test(input string name);
    idle(1);
    if (errors == test_errors) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, errors - test_errors);
      tests_bad++;
    end
    test_errors = errors;
  endtask

  // random 64-bit value built 11 bits at a time
  task automatic load_reg(input logic [4:0] rd);
    exec(enc_i(12'($urandom), 5'd0, 3'd0, rd, 7'h13));
    repeat (5) begin
      exec(enc_i(12'd11, rd, 3'd1, rd, 7'h13));
      exec(enc_i({1'b0, 11'($urandom)}, rd, 3'd6, rd, 7'h13));
    end
  endtask

  initial begin
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm;
    logic        alt;
    void'($urandom(32'h26ec));
    errors      = 0;
    test_errors = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    i_reset = 1'b1;
    i_valid = 1'b0;
    i_inst  = '0;
    i_pc    = '0;
    repeat (5) @(negedge i_clk);
    i_reset = 1'b0;

    exec(enc_i(12'd5, 5'd0, 3'd0, 5'd0, 7'h13)); // addi x0, x0, 5
    exec({20'hfffff, 5'd0, 7'h37});
    // x31 first so its reset value is read before it becomes the scratch
    for (int r = 31; r >= 0; r--) exec(enc_i(12'd0, 5'(r), 3'd0, 5'd31, 7'h13));
    finish_test("reset_and_x0");

    for (int r = 1; r <= 8; r++) load_reg(5'(r));
    for (int n = 0; n < 120; n++) begin
      f3  = 3'($urandom);
      alt = 1'($urandom);
      if ($urandom % 2) begin
        f7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        exec(enc_r(f7, 5'($urandom_range(1, 8)), 5'($urandom_range(1, 8)), f3,
                   5'($urandom_range(9, 30)), 7'h33));
      end else begin
        imm = 12'($urandom);
        if (f3 == 3'd1) imm = {6'h00, imm[5:0]};
        if (f3 == 3'd5) imm = {alt ? 6'h10 : 6'h00, imm[5:0]};
        exec(enc_i(imm, 5'($urandom_range(1, 8)), f3, 5'($urandom_range(9, 30)), 7'h13));
      end
    end
    finish_test("op_and_op_imm");

    exec(enc_i(12'hffb, 5'd0, 3'd0, 5'd20, 7'h13)); // x20 = -5
    exec(enc_r(7'h20, 5'd2, 5'd20, 3'd5, 5'd21, 7'h3b)); // sraw
    exec(enc_i({7'h20, 5'd3}, 5'd20, 3'd5, 5'd22, 7'h1b)); // sraiw
    for (int n = 0; n < 80; n++) begin
      f3  = ($urandom % 3 == 0) ? 3'd0 : (($urandom % 2) ? 3'd1 : 3'd5);
      alt = 1'($urandom);
      f7  = (alt && f3 != 3'd1) ? 7'h20 : 7'h00;
      if ($urandom % 2) begin
        exec(enc_r(f7, 5'($urandom_range(1, 8)), 5'($urandom_range(1, 8)), f3,
                   5'($urandom_range(9, 30)), 7'h3b));
      end else begin
        imm = (f3 == 3'd0) ? 12'($urandom) : {f3 == 3'd5 ? f7 : 7'h00, 5'($urandom)};
        exec(enc_i(imm, 5'($urandom_range(1, 8)), f3, 5'($urandom_range(9, 30)), 7'h1b));
      end
    end
    finish_test("word_ops");

    for (int n = 0; n < 20; n++) begin
      exec({20'($urandom), 5'($urandom_range(9, 30)), (n % 2) ? 7'h17 : 7'h37});
    end
    finish_test("lui_auipc");

    exec(enc_i(12'd0, 5'd1, 3'd0, 5'd10, 7'h13)); // x10 = x1 for the equal case
    foreach (f3_list[k]) begin
      exec(enc_b(13'($urandom) & ~13'd1, 5'd2, 5'd1, f3_list[k]));
      exec(enc_b(13'($urandom) & ~13'd1, 5'd10, 5'd1, f3_list[k]));
      exec(enc_b(13'($urandom) & ~13'd1, 5'd1, 5'd2, f3_list[k]));
    end
    for (int n = 0; n < 6; n++) begin
      exec(enc_j(21'($urandom) & ~21'd1, 5'($urandom_range(9, 30))));
      exec(enc_i(12'($urandom), 5'($urandom_range(1, 8)), 3'd0, 5'($urandom_range(9, 30)),
                 7'h67));
    end
    finish_test("branch_and_jump");

    exec(enc_i(12'd123, 5'd0, 3'd0, 5'd5, 7'h13));
    foreach (bad_list[k]) begin
      exec(bad_list[k]);
      exec(enc_i(12'd0, 5'd5, 3'd0, 5'd31, 7'h13)); // readback of x5
    end
    finish_test("illegal");

    idle(3);
    errors += dut.u_asserts.fail_count; // failures of the bound concurrent checks
    $display("tests passed %0d, tests failed %0d, errors %0d", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
rtl/rv64_pkg.sv
rtl/rv64_decoder.sv
rtl/rv64_regfile.sv
rtl/rv64_alu.sv
rtl/rv64_int_core.sv
testbench/rv64_int_core_asserts.sv
testbench/tb_rv64_int_core.sv

/* Bender.yml */
package:
  name: rv64_int_core

sources:
  - rtl/rv64_pkg.sv
  - rtl/rv64_decoder.sv
  - rtl/rv64_regfile.sv
  - rtl/rv64_alu.sv
  - rtl/rv64_int_core.sv
  - target: test
    files:
      - testbench/rv64_int_core_asserts.sv
      - testbench/tb_rv64_int_core.sv
